// File: verilog/hififo_pio_settings.svh
/*
 * hififo host register block settings
 * channel count and mask, register map and threshold widths
 */
`ifndef HIFIFO_PIO_SETTINGS_SVH
`define HIFIFO_PIO_SETTINGS_SVH

// channels 0-3 from the PC, 4-7 to the PC
`define HIFIFO_NUM_FIFOS 8

// one bit per built channel
`define HIFIFO_ENABLE 8'h11

// register indices on the 6-bit host index
`define HIFIFO_REG_INT_STATUS 0
`define HIFIFO_REG_ENABLE 1
`define HIFIFO_REG_RESET_SET 3
`define HIFIFO_REG_RESET_CLEAR 4
// channel i answers at base + 2*i
`define HIFIFO_REG_STATUS_BASE 16

// wake threshold compare widths
`define HIFIFO_FPC_NBITS 23
`define HIFIFO_TPC_NBITS 29

// extra fifo clock cycles of reset after release
`define HIFIFO_RESET_HOLD 15

`endif

// File: verilog/hififo_pio_pkg.sv
/*
 * hififo host register types
 * register index, host data, status word and per-channel mask
 */
`include "hififo_pio_settings.svh"

package hififo_pio_pkg;

   // decoded register index from the packet receiver
   typedef logic [5:0] pio_addr_t;

   // host write payload
   typedef logic [63:0] pio_data_t;

   // progress count, also the width of a read completion
   typedef logic [31:0] status_word_t;

   // one bit per channel
   typedef logic [`HIFIFO_NUM_FIFOS-1:0] fifo_mask_t;

endpackage

// File: verilog/pio_if.sv
/*
 * host programmed io bundle
 * decoded write and read strobes with register index and data
 */
`timescale 1ns/10ps
`include "hififo_pio_settings.svh"

interface pio_if;
   import hififo_pio_pkg::*;

   // single cycle strobes, no back-pressure
   logic      wr_valid;
   logic      rr_valid;
   pio_addr_t address;
   pio_data_t data;

   // read of the interrupt status word, shared by every channel
   logic      int_status_read;

   assign int_status_read = rr_valid && (address == pio_addr_t'(`HIFIFO_REG_INT_STATUS));

   modport source
   (
      output wr_valid,
      output rr_valid,
      output address,
      output data
   );

   modport sink
   (
      input wr_valid,
      input rr_valid,
      input address,
      input data,
      input int_status_read
   );

endinterface

// File: verilog/hififo_control.sv
/*
 * hififo host control
 * fifo reset register, register read-back, completion strobe
 * and the interrupt request to the pcie core
 */
`timescale 1ns/10ps
`include "hififo_pio_settings.svh"

module hififo_control
(
   input  logic                      clock,
   input  logic                      pci_reset,
   pio_if.sink                       pio,
   input  hififo_pio_pkg::status_word_t progress [`HIFIFO_NUM_FIFOS],
   input  hififo_pio_pkg::fifo_mask_t int_fire,
   input  hififo_pio_pkg::fifo_mask_t int_status,
   input  logic                      interrupt_rdy,
   output logic                      interrupt,
   output hififo_pio_pkg::status_word_t rc_data,
   output logic                      rc_done,
   output hififo_pio_pkg::fifo_mask_t fifo_reset_sys
);
   import hififo_pio_pkg::*;

   localparam fifo_mask_t ENABLE = `HIFIFO_ENABLE;

   status_word_t channel_word;
   fifo_mask_t   wr_byte;

   // only the low byte of a write reaches the reset register
   assign wr_byte = pio.data[`HIFIFO_NUM_FIFOS-1:0];

   // fifo reset register, every channel held in reset after pci_reset
   always_ff @(posedge clock)
   begin
      if (pci_reset)
      begin
         fifo_reset_sys <= '1;
      end
      else if (pio.wr_valid)
      begin
         if (pio.address == pio_addr_t'(`HIFIFO_REG_RESET_SET))
         begin
            fifo_reset_sys <= fifo_reset_sys | wr_byte;
         end
         else if (pio.address == pio_addr_t'(`HIFIFO_REG_RESET_CLEAR))
         begin
            fifo_reset_sys <= fifo_reset_sys & ~wr_byte;
         end
      end
   end

   // progress count at base + 2*i, zero for channels not built
   always_comb
   begin
      channel_word = '0;
      for (int i = 0; i < `HIFIFO_NUM_FIFOS; i++)
      begin
         if (ENABLE[i] &&
             (pio.address == pio_addr_t'(`HIFIFO_REG_STATUS_BASE + 2 * i)))
         begin
            channel_word = progress[i];
         end
      end
   end

   // completion data latched on the read strobe
   always_ff @(posedge clock)
   begin
      if (pio.rr_valid)
      begin
         case (pio.address)
            pio_addr_t'(`HIFIFO_REG_INT_STATUS):
            begin
               rc_data <= status_word_t'(int_status);
            end
            pio_addr_t'(`HIFIFO_REG_ENABLE):
            begin
               rc_data <= status_word_t'(ENABLE);
            end
            pio_addr_t'(`HIFIFO_REG_RESET_SET),
            pio_addr_t'(`HIFIFO_REG_RESET_CLEAR):
            begin
               rc_data <= status_word_t'(fifo_reset_sys);
            end
            default:
            begin
               rc_data <= channel_word;
            end
         endcase
      end
   end

   always_ff @(posedge clock)
   begin
      if (pci_reset)
      begin
         rc_done <= 1'b0;
      end
      else
      begin
         rc_done <= pio.rr_valid;
      end
   end

   // level until the core takes it; a new fire wins over ready and reset
   always_ff @(posedge clock)
   begin
      interrupt <= (|int_fire) | (interrupt & ~interrupt_rdy & ~pci_reset);
   end

endmodule

// File: verilog/hififo_interrupt.sv
/*
 * hififo channel wake unit
 * armed threshold on the progress count, fire pulse and sticky status
 */
`timescale 1ns/10ps
`include "hififo_pio_settings.svh"

module hififo_interrupt
#(
   parameter int NBITS = 23
)
(
   input  logic                                clock,
   input  logic                                pci_reset,
   pio_if.sink                                 pio,
   input  logic [$clog2(`HIFIFO_NUM_FIFOS)-1:0] channel,
   input  hififo_pio_pkg::status_word_t        count,
   output logic                                fire,
   output logic                                status
);
   import hififo_pio_pkg::*;

   pio_addr_t        own_index;
   logic [NBITS-1:0] threshold;
   logic             armed;
   logic             arm_write;
   logic             hit;

   // this channel's status register index
   assign own_index = pio_addr_t'(`HIFIFO_REG_STATUS_BASE) + pio_addr_t'({channel, 1'b0});

   assign arm_write = pio.wr_valid && (pio.address == own_index);
   assign hit = armed && (count[NBITS-1:0] >= threshold);

   always_ff @(posedge clock)
   begin
      if (arm_write)
      begin
         threshold <= pio.data[NBITS-1:0];
      end
   end

   always_ff @(posedge clock)
   begin
      if (pci_reset)
      begin
         armed  <= 1'b0;
         fire   <= 1'b0;
         status <= 1'b0;
      end
      else
      begin
         fire <= hit;
         // one shot, host must re-arm
         if (arm_write)
         begin
            armed <= 1'b1;
         end
         else if (hit)
         begin
            armed <= 1'b0;
         end
         // read returns the bit before it clears
         if (hit)
         begin
            status <= 1'b1;
         end
         else if (pio.int_status_read)
         begin
            status <= 1'b0;
         end
      end
   end

endmodule

// File: verilog/fifo_reset_sync.sv
/*
 * fifo channel reset synchronizer
 * brings the host reset into the fifo clock and stretches its release
 */
`timescale 1ns/10ps
`include "hififo_pio_settings.svh"

module fifo_reset_sync
(
   input  logic fifo_clock,
   input  logic reset_in,
   output logic fifo_reset
);

   localparam logic [3:0] HOLD = 4'(`HIFIFO_RESET_HOLD);

   // power up in reset until the first release is seen
   logic [1:0] sync_q = 2'b11;
   logic [3:0] hold_count = 4'd0;
   logic       reset_q = 1'b1;

   always_ff @(posedge fifo_clock)
   begin
      sync_q <= {sync_q[0], reset_in};
   end

   // restarts while reset is held, stops at HOLD
   always_ff @(posedge fifo_clock)
   begin
      if (sync_q[1])
      begin
         hold_count <= 4'd0;
      end
      else if (hold_count != HOLD)
      begin
         hold_count <= hold_count + 4'd1;
      end
   end

   // synchronized level asserts at once, release waits for the count
   always_ff @(posedge fifo_clock)
   begin
      reset_q <= sync_q[1] | (hold_count != HOLD);
   end

   assign fifo_reset = reset_q;

endmodule

// File: verilog/hififo_pio_top.sv
/*
 * hififo host register and interrupt block
 * decoded host strobes in, completions and interrupt out,
 * one wake unit and one reset synchronizer per built channel
 */
`timescale 1ns/10ps
`include "hififo_pio_settings.svh"

module hififo_pio_top
(
   // host side
   input  logic                         clock,
   input  logic                         pci_reset,
   input  logic                         pio_wr_valid,
   input  logic                         pio_rr_valid,
   input  hififo_pio_pkg::pio_addr_t    pio_address,
   input  hififo_pio_pkg::pio_data_t    pio_data,
   input  logic                         interrupt_rdy,
   output logic                         interrupt,
   output hififo_pio_pkg::status_word_t rc_data,
   output logic                         rc_done,
   // channel side
   input  hififo_pio_pkg::fifo_mask_t   fifo_clock,
   input  hififo_pio_pkg::status_word_t fifo_progress_0,
   input  hififo_pio_pkg::status_word_t fifo_progress_1,
   input  hififo_pio_pkg::status_word_t fifo_progress_2,
   input  hififo_pio_pkg::status_word_t fifo_progress_3,
   input  hififo_pio_pkg::status_word_t fifo_progress_4,
   input  hififo_pio_pkg::status_word_t fifo_progress_5,
   input  hififo_pio_pkg::status_word_t fifo_progress_6,
   input  hififo_pio_pkg::status_word_t fifo_progress_7,
   output hififo_pio_pkg::fifo_mask_t   fifo_reset
);
   import hififo_pio_pkg::*;

   localparam fifo_mask_t ENABLE = `HIFIFO_ENABLE;
   localparam int CH_BITS = $clog2(`HIFIFO_NUM_FIFOS);

   status_word_t progress [`HIFIFO_NUM_FIFOS];
   fifo_mask_t   int_fire;
   fifo_mask_t   int_status;
   fifo_mask_t   fifo_reset_sys;

   pio_if pio ();

   assign pio.wr_valid = pio_wr_valid;
   assign pio.rr_valid = pio_rr_valid;
   assign pio.address  = pio_address;
   assign pio.data     = pio_data;

   assign progress[0] = fifo_progress_0;
   assign progress[1] = fifo_progress_1;
   assign progress[2] = fifo_progress_2;
   assign progress[3] = fifo_progress_3;
   assign progress[4] = fifo_progress_4;
   assign progress[5] = fifo_progress_5;
   assign progress[6] = fifo_progress_6;
   assign progress[7] = fifo_progress_7;

   hififo_control u_control
   (
      .clock          (clock),
      .pci_reset      (pci_reset),
      .pio            (pio.sink),
      .progress       (progress),
      .int_fire       (int_fire),
      .int_status     (int_status),
      .interrupt_rdy  (interrupt_rdy),
      .interrupt      (interrupt),
      .rc_data        (rc_data),
      .rc_done        (rc_done),
      .fifo_reset_sys (fifo_reset_sys)
   );

   genvar i;
   generate
      for (i = 0; i < `HIFIFO_NUM_FIFOS; i++)
      begin : g_fifo
         if (ENABLE[i])
         begin : g_on
            // from-PC channels 0-3 compare fewer bits than to-PC 4-7
            localparam int NBITS = (i < 4) ? `HIFIFO_FPC_NBITS : `HIFIFO_TPC_NBITS;

            hififo_interrupt #(.NBITS(NBITS)) u_interrupt
            (
               .clock     (clock),
               .pci_reset (pci_reset),
               .pio       (pio.sink),
               .channel   (CH_BITS'(i)),
               .count     (progress[i]),
               .fire      (int_fire[i]),
               .status    (int_status[i])
            );

            fifo_reset_sync u_reset_sync
            (
               .fifo_clock (fifo_clock[i]),
               .reset_in   (fifo_reset_sys[i]),
               .fifo_reset (fifo_reset[i])
            );
         end
         else
         begin : g_off
            // channel not built, keep its fifo in reset
            assign int_fire[i]   = 1'b0;
            assign int_status[i] = 1'b0;
            assign fifo_reset[i] = 1'b1;
         end
      end
   endgenerate

endmodule

// File: verification/hififo_pio_tb.sv
/*
 * hififo host register block testbench
 * random host traffic and progress counts against a register,
 * threshold and interrupt model
 */
`timescale 1ns/10ps
`include "hififo_pio_settings.svh"

module hififo_pio_tb;
   import hififo_pio_pkg::*;

   localparam fifo_mask_t ENABLE = `HIFIFO_ENABLE;
   localparam int NUM = `HIFIFO_NUM_FIFOS;
   localparam int RESET_LIMIT = `HIFIFO_RESET_HOLD + 8;

   logic         clock;
   logic         pci_reset;
   logic         pio_wr_valid;
   logic         pio_rr_valid;
   pio_addr_t    pio_address;
   pio_data_t    pio_data;
   logic         interrupt_rdy;
   logic         interrupt;
   status_word_t rc_data;
   logic         rc_done;
   fifo_mask_t   fifo_clock;
   status_word_t progress [NUM];
   fifo_mask_t   fifo_reset;

   // model of the host visible state
   fifo_mask_t   model_reset;
   fifo_mask_t   model_status;
   fifo_mask_t   model_armed;
   status_word_t model_thr [NUM];
   logic         model_int;
   integer       seed;
   pio_data_t    data;

   always #5 clock = ~clock;

   assign fifo_clock = {NUM{clock}};

   hififo_pio_top uut
   (
      .clock           (clock),
      .pci_reset       (pci_reset),
      .pio_wr_valid    (pio_wr_valid),
      .pio_rr_valid    (pio_rr_valid),
      .pio_address     (pio_address),
      .pio_data        (pio_data),
      .interrupt_rdy   (interrupt_rdy),
      .interrupt       (interrupt),
      .rc_data         (rc_data),
      .rc_done         (rc_done),
      .fifo_clock      (fifo_clock),
      .fifo_progress_0 (progress[0]),
      .fifo_progress_1 (progress[1]),
      .fifo_progress_2 (progress[2]),
      .fifo_progress_3 (progress[3]),
      .fifo_progress_4 (progress[4]),
      .fifo_progress_5 (progress[5]),
      .fifo_progress_6 (progress[6]),
      .fifo_progress_7 (progress[7]),
      .fifo_reset      (fifo_reset)
   );

   task automatic abort_run(input string line);
      $display("%s", line);
      $display("Checks failed");
      $fatal(1, "simulation stopped");
   endtask

   task automatic check_word(input status_word_t got, input status_word_t exp,
                             input string what);
      if (got !== exp)
         abort_run($sformatf("MISMATCH at %0t: %s, got %h expected %h", $time, what, got, exp));
   endtask

   task automatic check_mask(input fifo_mask_t got, input fifo_mask_t exp, input string what);
      if (got !== exp)
         abort_run($sformatf("MISMATCH at %0t: %s, got %b expected %b", $time, what, got, exp));
   endtask

   task automatic check_bit(input logic got, input logic exp, input string what);
      if (got !== exp)
         abort_run($sformatf("MISMATCH at %0t: %s, got %b expected %b", $time, what, got, exp));
   endtask

   function automatic pio_addr_t status_index(input int ch);
      return pio_addr_t'(`HIFIFO_REG_STATUS_BASE + 2 * ch);
   endfunction

   // from-PC channels compare fewer count bits
   function automatic status_word_t width_mask(input int ch);
      int nbits;
      nbits = (ch < 4) ? `HIFIFO_FPC_NBITS : `HIFIFO_TPC_NBITS;
      return status_word_t'((64'd1 << nbits) - 64'd1);
   endfunction

   function automatic logic would_fire(input int ch);
      return model_armed[ch] && ((progress[ch] & width_mask(ch)) >= model_thr[ch]);
   endfunction

   // register map as the host sees it
   function automatic status_word_t expected_read(input pio_addr_t addr);
      status_word_t word;
      word = '0;
      if (addr == pio_addr_t'(`HIFIFO_REG_INT_STATUS))
         word = status_word_t'(model_status);
      else if (addr == pio_addr_t'(`HIFIFO_REG_ENABLE))
         word = status_word_t'(ENABLE);
      else if (addr == pio_addr_t'(`HIFIFO_REG_RESET_SET) ||
               addr == pio_addr_t'(`HIFIFO_REG_RESET_CLEAR))
         word = status_word_t'(model_reset);
      for (int i = 0; i < NUM; i++)
         if (ENABLE[i] && addr == status_index(i))
            word = progress[i];
      return word;
   endfunction

   task automatic host_write(input pio_addr_t addr, input pio_data_t value);
      @(posedge clock);
      #1;
      pio_wr_valid = 1'b1;
      pio_address = addr;
      pio_data = value;
      @(posedge clock);
      #1;
      pio_wr_valid = 1'b0;
   endtask

   task automatic read_check(input pio_addr_t addr, input string what);
      status_word_t exp;
      int           waited;
      exp = expected_read(addr);
      @(posedge clock);
      #1;
      check_bit(rc_done, 1'b0, "rc_done low before the read");
      pio_rr_valid = 1'b1;
      pio_address = addr;
      @(posedge clock);
      #1;
      pio_rr_valid = 1'b0;
      waited = 0;
      @(negedge clock);
      while (rc_done !== 1'b1 && waited < 8)
      begin
         waited++;
         @(negedge clock);
      end
      if (rc_done !== 1'b1)
         abort_run($sformatf("timed out waiting for rc_done on a read of index %0d", addr));
      check_bit(logic'(waited == 0), 1'b1, "rc_done one cycle after rr_valid");
      check_word(rc_data, exp, what);
      // interrupt status clears on read
      if (addr == pio_addr_t'(`HIFIFO_REG_INT_STATUS))
         model_status = '0;
   endtask

   task automatic wait_fifo_reset(input fifo_mask_t exp);
      int cycles;
      cycles = 0;
      @(negedge clock);
      while (fifo_reset !== exp && cycles < RESET_LIMIT)
      begin
         check_mask(fifo_reset & ~ENABLE, ~ENABLE, "disabled channel fifo_reset");
         cycles++;
         @(negedge clock);
      end
      if (fifo_reset !== exp)
         abort_run($sformatf("fifo_reset did not settle to %b in time", exp));
   endtask

   task automatic wait_interrupt(input logic level, input string what);
      int cycles;
      cycles = 0;
      @(negedge clock);
      while (interrupt !== level && cycles < 12)
      begin
         cycles++;
         @(negedge clock);
      end
      if (interrupt !== level)
         abort_run({"timed out waiting for interrupt ", what});
   endtask

   task automatic hold_check(input int cycles, input string what);
      repeat (cycles)
      begin
         @(negedge clock);
         check_bit(interrupt, model_int, what);
      end
   endtask

   // after a count or arm change, either expect a fire or a quiet line
   task automatic settle_channel(input int ch);
      if (would_fire(ch))
      begin
         wait_interrupt(1'b1, "to rise after the threshold");
         model_status[ch] = 1'b1;
         model_armed[ch] = 1'b0;
         model_int = 1'b1;
         hold_check(4, "interrupt held while interrupt_rdy is low");
         @(posedge clock);
         #1;
         interrupt_rdy = 1'b1;
         @(posedge clock);
         #1;
         interrupt_rdy = 1'b0;
         model_int = 1'b0;
         wait_interrupt(1'b0, "to fall after interrupt_rdy");
      end
      else
         hold_check(4, "interrupt with no fire");
   endtask

   task automatic set_progress(input int ch, input status_word_t value);
      @(posedge clock);
      #1;
      progress[ch] = value;
      settle_channel(ch);
   endtask

   task automatic wake_test(input int ch);
      status_word_t mask;
      pio_data_t    arm;
      mask = width_mask(ch);
      set_progress(ch, '0);
      arm = {$random(seed), $random(seed)};
      if ((arm[31:0] & mask) == '0)
         arm[0] = 1'b1;
      model_thr[ch] = arm[31:0] & mask;
      model_armed[ch] = 1'b1;
      host_write(status_index(ch), arm);
      settle_channel(ch);
      // reach the threshold exactly with random upper count bits
      set_progress(ch, (status_word_t'($random(seed)) & ~mask) | model_thr[ch]);
      read_check(`HIFIFO_REG_INT_STATUS, "sticky status after fire");
      read_check(`HIFIFO_REG_INT_STATUS, "status cleared by read");
      // now disarmed so a higher count stays quiet
      set_progress(ch, '1);
      read_check(`HIFIFO_REG_INT_STATUS, "status with no second fire");
      model_armed[ch] = 1'b1;
      host_write(status_index(ch), arm);
      settle_channel(ch);
      read_check(`HIFIFO_REG_INT_STATUS, "status after re-arm");
      set_progress(ch, '0);
   endtask

   initial
   begin
      seed = 60;
      clock = 1'b0;
      pci_reset = 1'b1;
      pio_wr_valid = 1'b0;
      pio_rr_valid = 1'b0;
      pio_address = '0;
      pio_data = '0;
      interrupt_rdy = 1'b0;
      for (int i = 0; i < NUM; i++)
      begin
         progress[i] = '0;
         model_thr[i] = '0;
      end
      model_reset = '1;
      model_status = '0;
      model_armed = '0;
      model_int = 1'b0;
      repeat (3) @(posedge clock);
      #1;
      pci_reset = 1'b0;

      // state after reset
      check_bit(interrupt, 1'b0, "interrupt after reset");
      wait_fifo_reset('1);
      read_check(`HIFIFO_REG_ENABLE, "enable mask");
      read_check(`HIFIFO_REG_RESET_SET, "reset register at set index");
      read_check(`HIFIFO_REG_RESET_CLEAR, "reset register at clear index");
      read_check(2, "unused index 2");
      read_check(63, "unused index 63");
      repeat (8)
         read_check(pio_addr_t'($random(seed)), "random index after reset");

      // reset register set and clear
      repeat (12)
      begin
         data = {$random(seed), $random(seed)};
         if (data[63])
         begin
            model_reset = model_reset | data[7:0];
            host_write(`HIFIFO_REG_RESET_SET, data);
         end
         else
         begin
            model_reset = model_reset & ~data[7:0];
            host_write(`HIFIFO_REG_RESET_CLEAR, data);
         end
         read_check(`HIFIFO_REG_RESET_SET, "reset register read back");
         wait_fifo_reset(model_reset | ~ENABLE);
      end
      model_reset = '0;
      host_write(`HIFIFO_REG_RESET_CLEAR, 64'hff);
      wait_fifo_reset(~ENABLE);

      // progress read back
      for (int i = 0; i < NUM; i++)
      begin
         @(posedge clock);
         #1;
         progress[i] = $random(seed);
         read_check(status_index(i), "progress count");
         read_check(status_index(i) + pio_addr_t'(1), "odd index beside progress");
         @(posedge clock);
         #1;
         progress[i] = '0;
      end

      // wake thresholds and interrupt
      for (int i = 0; i < NUM; i++)
         if (ENABLE[i])
            wake_test(i);

      $display("All checks passed");
      $finish;
   end

endmodule

// File: hififo_pio.f
+incdir+verilog
verilog/hififo_pio_pkg.sv
verilog/pio_if.sv
verilog/hififo_control.sv
verilog/hififo_interrupt.sv
verilog/fifo_reset_sync.sv
verilog/hififo_pio_top.sv
verification/hififo_pio_tb.sv

// File: Makefile
# Verilator build for the hififo host register block

VERILATOR ?= verilator
TOP       ?= hififo_pio_tb
FILELIST  ?= hififo_pio.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --timing --timescale 1ns/10ps
PASS_TEXT ?= All checks passed

SOURCES = $(wildcard verilog/*.sv verilog/*.svh verification/*.sv)
BINARY  = $(BUILD_DIR)/V$(TOP)

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

$(BINARY): $(FILELIST) $(SOURCES)
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

sim: $(BINARY)
	-./$(BINARY) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "$(PASS_TEXT)" $(LOG); then \
		echo "simulation passed"; \
	else \
		echo "simulation failed, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
